// File: cpu16.f
design/cpu16_pkg.sv
design/fetch_stage.sv
design/register_file.sv
design/decode_stage.sv
design/execute_stage.sv
design/writeback_stage.sv
design/cpu16_top.sv
tests/cpu16_tb.sv

// File: design/cpu16_pkg.sv
package cpu16_pkg;

        ////////////////////
        // Widths
        ////////////////////

        // Data and instruction word
        typedef logic [15:0] word_t;
        // Register number
        typedef logic [2:0]  reg_idx_t;
        // Top five bits of an instruction
        typedef logic [4:0]  opcode_t;
        // ALU function select
        typedef logic [1:0]  alu_sel_t;

        localparam int NUM_REGS = 8;

        ////////////////////
        // Encodings
        ////////////////////

        localparam opcode_t OP_HALT = 5'b00000;
        localparam opcode_t OP_NOP  = 5'b00001;
        localparam opcode_t OP_ADDI = 5'b01000;
        localparam opcode_t OP_LBI  = 5'b11000;
        // ADD, SUB, XOR, ANDN share one opcode
        localparam opcode_t OP_RFMT = 5'b11011;

        // Low two bits of a register-format word
        localparam alu_sel_t ALU_ADD  = 2'b00;
        localparam alu_sel_t ALU_SUB  = 2'b01;
        localparam alu_sel_t ALU_XOR  = 2'b10;
        localparam alu_sel_t ALU_ANDN = 2'b11;

        // Bubble loaded by fetch
        localparam word_t NOP_WORD = {OP_NOP, 11'b0};

        ////////////////////
        // Pipeline bundles
        ////////////////////

        typedef struct packed {
                logic  valid;
                word_t instr;
        } if_id_t;

        typedef struct packed {
                logic     valid;
                logic     reg_write;
                logic     halt;
                logic     illegal;
                // Second ALU operand from imm
                logic     use_imm;
                // LBI result is imm itself
                logic     pass_imm;
                alu_sel_t alu_sel;
                reg_idx_t rs;
                reg_idx_t rt;
                reg_idx_t rd;
                word_t    operand_a;
                word_t    operand_b;
                word_t    imm;
        } id_ex_t;

        typedef struct packed {
                logic     valid;
                logic     reg_write;
                logic     halt;
                logic     illegal;
                reg_idx_t rd;
                word_t    result;
        } ex_wb_t;

        // Register write, also the commit record
        typedef struct packed {
                reg_idx_t rd;
                word_t    data;
        } commit_t;

endpackage

// File: design/cpu16_top.sv
`timescale 1ns/10ps

module cpu16_top (
        input  logic               clk,
        input  logic               reset,
        output cpu16_pkg::word_t   imem_addr,
        input  cpu16_pkg::word_t   imem_data,
        output logic               commit_valid,
        output cpu16_pkg::commit_t commit,
        output logic               halted,
        output logic               err
);
        import cpu16_pkg::*;

        ////////////////////
        // Stage to stage
        ////////////////////

        if_id_t  if_id;
        id_ex_t  id_ex;
        ex_wb_t  ex_wb;
        logic    halt_pending;
        // Register write, also the forwarding source
        logic    rf_write_en;
        commit_t rf_write;

        // Every register write shows on the commit port
        assign commit_valid = rf_write_en;
        assign commit       = rf_write;

        fetch_stage fetch (
                //Inputs
                .clk(clk),
                .reset(reset),
                .halt_pending(halt_pending),
                .imem_data(imem_data),
                //Outputs
                .imem_addr(imem_addr),
                .if_id(if_id)
        );

        decode_stage decode (
                //Inputs
                .clk(clk),
                .reset(reset),
                .if_id(if_id),
                .rf_write_en(rf_write_en),
                .rf_write(rf_write),
                //Outputs
                .id_ex(id_ex),
                .halt_pending(halt_pending)
        );

        execute_stage execute (
                //Inputs
                .clk(clk),
                .reset(reset),
                .id_ex(id_ex),
                .fwd_en(rf_write_en),
                .fwd(rf_write),
                //Outputs
                .ex_wb(ex_wb)
        );

        writeback_stage writeback (
                //Inputs
                .clk(clk),
                .reset(reset),
                .ex_wb(ex_wb),
                //Outputs
                .rf_write_en(rf_write_en),
                .rf_write(rf_write),
                .halted(halted),
                .err(err)
        );

endmodule

// File: design/decode_stage.sv
`timescale 1ns/10ps

module decode_stage (
        input  logic               clk,
        input  logic               reset,
        input  cpu16_pkg::if_id_t  if_id,
        input  logic               rf_write_en,
        input  cpu16_pkg::commit_t rf_write,
        output cpu16_pkg::id_ex_t  id_ex,
        output logic               halt_pending
);
        import cpu16_pkg::*;

        opcode_t  opcode;
        reg_idx_t rs;
        reg_idx_t rt;
        word_t    rd_data_a;
        word_t    rd_data_b;
        word_t    imm5_ext;
        word_t    imm8_ext;
        logic     is_halt;
        logic     halt_seen;
        id_ex_t   id_ex_next;

        ////////////////////
        // Field split
        ////////////////////

        assign opcode = if_id.instr[15:11];
        assign rs     = if_id.instr[10:8];
        assign rt     = if_id.instr[7:5];

        // Sign extension of ADDI and LBI immediates
        assign imm5_ext = {{11{if_id.instr[4]}}, if_id.instr[4:0]};
        assign imm8_ext = {{8{if_id.instr[7]}}, if_id.instr[7:0]};

        // Read in decode, written by writeback
        register_file regfile (
                //Inputs
                .clk(clk),
                .reset(reset),
                .rd_idx_a(rs),
                .rd_idx_b(rt),
                .write_en(rf_write_en),
                .write(rf_write),
                //Outputs
                .rd_data_a(rd_data_a),
                .rd_data_b(rd_data_b)
        );

        ////////////////////
        // Control decode
        ////////////////////

        always_comb begin
                id_ex_next           = '0;
                // Nothing after a HALT moves on as valid
                id_ex_next.valid     = if_id.valid & ~halt_seen;
                id_ex_next.rs        = rs;
                id_ex_next.rt        = rt;
                id_ex_next.rd        = rt;
                id_ex_next.operand_a = rd_data_a;
                id_ex_next.operand_b = rd_data_b;
                id_ex_next.imm       = imm5_ext;
                id_ex_next.alu_sel   = ALU_ADD;
                case (opcode)
                        OP_HALT: begin
                                // Travels on without a write
                                id_ex_next.halt = 1'b1;
                        end
                        OP_NOP: begin
                                // No control bits
                        end
                        OP_ADDI: begin
                                id_ex_next.reg_write = 1'b1;
                                id_ex_next.use_imm   = 1'b1;
                                id_ex_next.rd        = if_id.instr[7:5];
                        end
                        OP_LBI: begin
                                id_ex_next.reg_write = 1'b1;
                                id_ex_next.pass_imm  = 1'b1;
                                id_ex_next.rd        = if_id.instr[10:8];
                                id_ex_next.imm       = imm8_ext;
                        end
                        OP_RFMT: begin
                                id_ex_next.reg_write = 1'b1;
                                id_ex_next.alu_sel   = if_id.instr[1:0];
                                id_ex_next.rd        = if_id.instr[4:2];
                        end
                        default: begin
                                // Unknown opcode, later raises err
                                id_ex_next.illegal = 1'b1;
                        end
                endcase
        end

        ////////////////////
        // Halt tracking
        ////////////////////

        assign is_halt = if_id.valid && (opcode == OP_HALT);

        // Rises in the same cycle the HALT is decoded
        assign halt_pending = halt_seen | is_halt;

        always_ff @(posedge clk) begin
                if (reset) begin
                        halt_seen <= 1'b0;
                end else if (is_halt) begin
                        halt_seen <= 1'b1;
                end
        end

        // ID/EX register
        always_ff @(posedge clk) begin
                if (reset) begin
                        id_ex.valid     <= 1'b0;
                        id_ex.reg_write <= 1'b0;
                        id_ex.halt      <= 1'b0;
                        id_ex.illegal   <= 1'b0;
                end else begin
                        id_ex <= id_ex_next;
                end
        end

endmodule

// File: design/execute_stage.sv
`timescale 1ns/10ps

module execute_stage (
        input  logic               clk,
        input  logic               reset,
        input  cpu16_pkg::id_ex_t  id_ex,
        input  logic               fwd_en,
        input  cpu16_pkg::commit_t fwd,
        output cpu16_pkg::ex_wb_t  ex_wb
);
        import cpu16_pkg::*;

        logic   fwd_a;
        logic   fwd_b;
        word_t  src_a;
        word_t  reg_b;
        word_t  src_b;
        word_t  alu_out;
        word_t  result;
        ex_wb_t ex_wb_next;

        ////////////////////
        // Forwarding
        ////////////////////

        // Previous instruction sits in EX/WB now
        assign fwd_a = fwd_en && (fwd.rd == id_ex.rs);
        assign fwd_b = fwd_en && (fwd.rd == id_ex.rt);

        assign src_a = fwd_a ? fwd.data : id_ex.operand_a;
        assign reg_b = fwd_b ? fwd.data : id_ex.operand_b;

        // ADDI takes the extended immediate
        assign src_b = id_ex.use_imm ? id_ex.imm : reg_b;

        ////////////////////
        // ALU
        ////////////////////

        // Wraps modulo 2^16
        always_comb begin
                case (id_ex.alu_sel)
                        ALU_ADD:  alu_out = src_a + src_b;
                        ALU_SUB:  alu_out = src_a - src_b;
                        ALU_XOR:  alu_out = src_a ^ src_b;
                        ALU_ANDN: alu_out = src_a & ~src_b;
                        default:  alu_out = src_a + src_b;
                endcase
        end

        // LBI bypasses the ALU
        assign result = id_ex.pass_imm ? id_ex.imm : alu_out;

        assign ex_wb_next = '{
                valid:     id_ex.valid,
                reg_write: id_ex.reg_write,
                halt:      id_ex.halt,
                illegal:   id_ex.illegal,
                rd:        id_ex.rd,
                result:    result
        };

        ////////////////////
        // EX/WB register
        ////////////////////

        always_ff @(posedge clk) begin
                if (reset) begin
                        ex_wb.valid     <= 1'b0;
                        ex_wb.reg_write <= 1'b0;
                        ex_wb.halt      <= 1'b0;
                        ex_wb.illegal   <= 1'b0;
                end else begin
                        ex_wb <= ex_wb_next;
                end
        end

endmodule

// File: design/fetch_stage.sv
`timescale 1ns/10ps

module fetch_stage (
        input  logic              clk,
        input  logic              reset,
        input  logic              halt_pending,
        input  cpu16_pkg::word_t  imem_data,
        output cpu16_pkg::word_t  imem_addr,
        output cpu16_pkg::if_id_t if_id
);
        import cpu16_pkg::*;

        // Word-addressed program counter
        word_t pc;

        assign imem_addr = pc;

        ////////////////////
        // Program counter
        ////////////////////

        always_ff @(posedge clk) begin
                if (reset) begin
                        pc <= '0;
                end else if (!halt_pending) begin
                        // One instruction word per cycle
                        pc <= pc + 16'd1;
                end
                // Frozen while a HALT is pending
        end

        ////////////////////
        // IF/ID register
        ////////////////////

        always_ff @(posedge clk) begin
                if (reset || halt_pending) begin
                        // Bubble, never decoded as valid
                        if_id <= '{valid: 1'b0, instr: NOP_WORD};
                end else begin
                        // Word answered for the current address
                        if_id <= '{valid: 1'b1, instr: imem_data};
                end
        end

endmodule

// File: design/register_file.sv
`timescale 1ns/10ps

module register_file (
        input  logic                clk,
        input  logic                reset,
        input  cpu16_pkg::reg_idx_t rd_idx_a,
        input  cpu16_pkg::reg_idx_t rd_idx_b,
        output cpu16_pkg::word_t    rd_data_a,
        output cpu16_pkg::word_t    rd_data_b,
        input  logic                write_en,
        input  cpu16_pkg::commit_t  write
);
        import cpu16_pkg::*;

        word_t regs [NUM_REGS];

        logic hit_a;
        logic hit_b;

        // Write port
        always_ff @(posedge clk) begin
                if (reset) begin
                        for (int i = 0; i < NUM_REGS; i++) begin
                                regs[i] <= '0;
                        end
                end else if (write_en) begin
                        regs[write.rd] <= write.data;
                end
        end

        ////////////////////
        // Write-through
        ////////////////////

        // Same-cycle write seen by decode
        assign hit_a = write_en && (write.rd == rd_idx_a);
        assign hit_b = write_en && (write.rd == rd_idx_b);

        // Instruction two places ahead lands here
        assign rd_data_a = hit_a ? write.data : regs[rd_idx_a];
        assign rd_data_b = hit_b ? write.data : regs[rd_idx_b];

endmodule

// File: design/writeback_stage.sv
`timescale 1ns/10ps

module writeback_stage (
        input  logic               clk,
        input  logic               reset,
        input  cpu16_pkg::ex_wb_t  ex_wb,
        output logic               rf_write_en,
        output cpu16_pkg::commit_t rf_write,
        output logic               halted,
        output logic               err
);
        import cpu16_pkg::*;

        logic halt_now;
        logic err_now;
        logic halt_seen;
        logic err_seen;

        assign halt_now = ex_wb.valid & ex_wb.halt;
        assign err_now  = ex_wb.valid & ex_wb.illegal;

        // High from the cycle the entry reaches EX/WB
        assign halted = halt_seen | halt_now;
        assign err    = err_seen | err_now;

        // Register write, no writes once halted
        assign rf_write_en = ex_wb.valid & ex_wb.reg_write & ~halt_seen;
        assign rf_write    = commit_t'{rd: ex_wb.rd, data: ex_wb.result};

        // Sticky until reset
        always_ff @(posedge clk) begin
                if (reset) begin
                        halt_seen <= 1'b0;
                        err_seen  <= 1'b0;
                end else begin
                        if (halt_now)
                                halt_seen <= 1'b1;
                        if (err_now)
                                err_seen <= 1'b1;
                end
        end

endmodule

// File: run_sim.sh
#!/bin/sh
# Build with Verilator and run; pass only if the pass line is printed
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module cpu16_tb -f cpu16.f -o cpu16_sim \
        && ./obj_dir/cpu16_sim | tee /dev/stderr | grep -qF "=== PASS ===" \
        && echo "Simulation passed" \
        || { echo "Simulation failed"; exit 1; }

// File: tests/cpu16_tb.sv
`timescale 1ns/10ps

module cpu16_tb;
        import cpu16_pkg::*;

        localparam int RUN_LIMIT  = 200;
        localparam int HOLD_WATCH = 8;
        localparam int PROG_WORDS = 32;
        localparam int EXP_BASE   = 32;

        logic    clk;
        logic    reset;
        word_t   imem_addr;
        word_t   imem_data;
        logic    commit_valid;
        commit_t commit;
        logic    halted;
        logic    err;

        // Program image, then expected {rd, data} records
        logic [19:0] testdata [64];

        int unsigned seed_status;
        int          expected_count;
        int          commit_count;
        int          cycle;
        logic        err_seen;
        word_t       frozen_addr;

        cpu16_top UUT (
                .clk(clk),
                .reset(reset),
                .imem_addr(imem_addr),
                .imem_data(imem_data),
                .commit_valid(commit_valid),
                .commit(commit),
                .halted(halted),
                .err(err)
        );

        ////////////////////
        // Clock
        ////////////////////

        initial begin
                clk = 1'b0;
                forever #10 clk = ~clk;
        end

        ////////////////////
        // Failure handling
        ////////////////////

        task automatic report_failure();
                $display("=== FAIL ===");
                $fatal(1, "Simulation stopped at the first error");
        endtask

        task automatic check_word(input string name, input word_t expected, input word_t actual);
                if (actual !== expected) begin
                        $display("CHECK FAILED at %0t: %s expected %h, actual %h",
                                 $time, name, expected, actual);
                        report_failure();
                end
        endtask

        task automatic check_reg(input string name, input reg_idx_t expected,
                                 input reg_idx_t actual);
                if (actual !== expected) begin
                        $display("CHECK FAILED at %0t: %s expected %0d, actual %0d",
                                 $time, name, expected, actual);
                        report_failure();
                end
        endtask

        task automatic check_flag(input string name, input logic expected, input logic actual);
                if (actual !== expected) begin
                        $display("CHECK FAILED at %0t: %s expected %b, actual %b",
                                 $time, name, expected, actual);
                        report_failure();
                end
        endtask

        ////////////////////
        // Instruction memory
        ////////////////////

        // Unknown or out-of-range fetches read as NOP
        function automatic word_t program_word(input word_t addr);
                logic [19:0] entry;
                if ($isunknown(addr) || addr >= 16'(PROG_WORDS))
                        return NOP_WORD;
                entry = testdata[addr[4:0]];
                if ($isunknown(entry))
                        return NOP_WORD;
                return entry[15:0];
        endfunction

        // Answer for the address set at this edge
        always @(posedge clk) begin
                #1;
                imem_data = program_word(imem_addr);
        end

        // Next expected record against the commit port
        task automatic compare_commit();
                logic [19:0] record;
                if (commit_count >= expected_count) begin
                        $display("Commit to r%0d seen after the expected list ran out", commit.rd);
                        report_failure();
                end
                record = testdata[EXP_BASE + commit_count];
                check_reg("commit.rd", record[18:16], commit.rd);
                check_word("commit.data", record[15:0], commit.data);
                commit_count++;
        endtask

        ////////////////////
        // Main sequence
        ////////////////////

        initial begin
                seed_status = $urandom(17);
                reset = 1'b1;
                imem_data = NOP_WORD;
                commit_count = 0;
                err_seen = 1'b0;
                $readmemh("tests/cpu16_testdata.hex", testdata);

                // List ends at the all-ones record
                expected_count = 0;
                while (expected_count < 32 &&
                       testdata[EXP_BASE + expected_count] !== 20'hFFFFF)
                        expected_count++;

                repeat (4) @(posedge clk);
                #1;
                reset = 1'b0;

                // Quiet state right after reset
                @(negedge clk);
                check_word("imem_addr", 16'h0000, imem_addr);
                check_flag("commit_valid", 1'b0, commit_valid);
                check_flag("halted", 1'b0, halted);
                check_flag("err", 1'b0, err);

                // Commits until the HALT reaches writeback
                cycle = 0;
                while (!halted) begin
                        @(negedge clk);
                        cycle++;
                        if (cycle > RUN_LIMIT) begin
                                $display("Timeout: halted did not rise within %0d cycles",
                                         RUN_LIMIT);
                                report_failure();
                        end
                        if (commit_count == 0)
                                check_flag("err", 1'b0, err);
                        // Illegal word raises err without a write
                        if (err && !err_seen) begin
                                check_flag("commit_valid", 1'b0, commit_valid);
                                err_seen = 1'b1;
                        end
                        if (err_seen)
                                check_flag("err", 1'b1, err);
                        if (halted)
                                check_flag("commit_valid", 1'b0, commit_valid);
                        else if (commit_valid)
                                compare_commit();
                end

                // PC frozen and nothing after HALT commits
                frozen_addr = imem_addr;
                for (int i = 0; i < HOLD_WATCH; i++) begin
                        @(negedge clk);
                        check_word("imem_addr", frozen_addr, imem_addr);
                        check_flag("commit_valid", 1'b0, commit_valid);
                        check_flag("halted", 1'b1, halted);
                end
                check_flag("err", 1'b1, err);

                if (commit_count != expected_count) begin
                        $display("Run ended with %0d commits where %0d were expected",
                                 commit_count, expected_count);
                        report_failure();
                end else begin
                        $display("=== PASS ===");
                        $finish;
                end
        end

endmodule

// File: tests/cpu16_testdata.hex
// Lines 0-31 program word in bits 15:0
// Lines 32-63 expected commit, rd in bits 18:16 and data in bits 15:0
@00
0C125
0C2F0
0417D
0DB50
0DC35
0DD5A
0A800
0DEBF
04725
0D928
00800
00000
0C377
0C466
@20
10025
2FFF0
30022
40012
5FFED
6001D
70010
10015
2002A
FFFFF
